// File: project.f
design/siggen_pkg.sv
design/spi_frame_fsm.sv
design/control_registers.sv
design/pattern_memory.sv
design/playback_sequencer.sv
design/siggen_top.sv
tests/siggen_tb.sv

// File: Makefile
# verilator flow for the pattern generator
TOP := siggen_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

obj_dir/V$(TOP): project.f design/*.sv tests/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

# pass only when the pass line shows up in the simulator output
sim: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: tests/siggen_tb.sv
// testbench for the pattern generator with SPI master, playback checker and watchdog
`timescale 1ns/1ps

module siggen_tb import siggen_pkg::*; ();
	localparam int ADDR_BITS    = 12;
	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	// half an sck period in clock cycles
	localparam int SCK_HALF     = 4;
	localparam int NUM_WORDS    = 12;
	localparam logic [7:0] CMD_READ = 8'h52;
	// loop bounds for the playback tests
	localparam int LOOP_START = 16;
	localparam int LOOP_END   = 40;
	localparam int NEW_START  = 8;
	localparam int NEW_END    = 20;
	localparam int MAX_LOOP   = 40;

	// ----------------------------------------------------------------------
	// run length for the watchdog
	// ----------------------------------------------------------------------
	// select setup + bits + select hold + gap
	localparam int FRAME_CYCLES   = 1 + FRAME_BITS * 2 * SCK_HALF + SCK_HALF + 8;
	localparam int NUM_FRAMES     = 4 + 5 + 2 * NUM_WORDS + 1 + 2 + 1;
	localparam int PLAY_CYCLES    = 4 * (4 * MAX_LOOP) + 16;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + PLAY_CYCLES + 200;

	logic clock_ro;
	logic reset4_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0;
	logic spi_ce1;
	logic spi_miso;
	sample_t sample;
	logic ready;

	int error_count;
	logic [31:0] rng_state;
	// expected memory contents by byte address
	logic [7:0] model_bytes [4*NUM_WORDS];

	siggen_top #(.PATTERN_ADDR_BITS(ADDR_BITS)) siggen_top_i (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_ce0(spi_ce0), .spi_ce1(spi_ce1),
		.spi_miso(spi_miso), .sample(sample), .ready(ready)
	);

	initial begin
		clock_ro = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock_ro = ~clock_ro;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			error_count++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	// one full 56-bit mode 0 frame sent msb first
	// the 32 data bits seen on miso come back in rx_data
	task automatic spi_transfer(input logic sel, input logic [7:0] command,
			input logic [15:0] address, input logic [31:0] data, output logic [31:0] rx_data);
		spi_frame_t tx;
		logic [FRAME_BITS-1:0] tx_bits;
		logic [FRAME_BITS-1:0] rx_bits;
		int i;
		tx.command = command;
		tx.address = address;
		tx.data    = data;
		tx_bits    = tx;
		rx_bits    = '0;
		@(negedge clock_ro);
		if (sel)
			spi_ce1 = 1'b0;
		else
			spi_ce0 = 1'b0;
		for (i = FRAME_BITS - 1; i >= 0; i--) begin
			spi_mosi = tx_bits[i];
			repeat (SCK_HALF) @(negedge clock_ro);
			// master samples miso on rising sck
			rx_bits  = {rx_bits[FRAME_BITS-2:0], spi_miso};
			spi_sclk = 1'b1;
			repeat (SCK_HALF) @(negedge clock_ro);
			spi_sclk = 1'b0;
		end
		repeat (SCK_HALF) @(negedge clock_ro);
		spi_ce0  = 1'b1;
		spi_ce1  = 1'b1;
		spi_mosi = 1'b0;
		// strobe lands 3 cycles after select rises and the write one cycle later
		repeat (8) @(negedge clock_ro);
		rx_data = rx_bits[31:0];
	endtask

	// find a sync and then check whole loops byte by byte
	task automatic compare_loops(input int start_byte, input int end_byte, input int loops);
		int waited;
		int n;
		int k;
		waited = 0;
		while (sample.sync !== 1'b1 && waited < 4 * MAX_LOOP) begin
			@(negedge clock_ro);
			waited++;
		end
		assert (sample.sync === 1'b1) else begin
			error_count++;
			$display("no frame sync seen within %0d cycles", waited);
		end
		for (n = 0; n < loops; n++) begin
			for (k = 0; k < end_byte - start_byte; k++) begin
				expect_value("sample.data", 32'(sample.data), 32'(model_bytes[start_byte + k]));
				expect_value("sample.sync", 32'(sample.sync), 32'(k == 0));
				@(negedge clock_ro);
			end
		end
		// next loop starts exactly one loop length on
		expect_value("sample.sync", 32'(sample.sync), 32'd1);
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic reset_defaults();
		logic [31:0] rx;
		int i;
		repeat (RESET_CYCLES) begin
			@(negedge clock_ro);
			expect_value("ready", 32'(ready), 32'd0);
			expect_value("sample", 32'(sample), 32'd0);
		end
		reset4_word_clock = 1'b0;
		@(negedge clock_ro);
		expect_value("ready", 32'(ready), 32'd1);
		// defaults with index 3 unmapped
		for (i = 0; i < 4; i++) begin
			spi_transfer(1'b0, CMD_READ, 16'(i), 32'd0, rx);
			expect_value($sformatf("register %0d", i), rx, (i == 1) ? 32'd4 : 32'd0);
		end
	endtask

	task automatic register_access();
		logic [31:0] rx;
		spi_transfer(1'b0, CMD_WRITE, 16'(REG_START), 32'(LOOP_START), rx);
		// read frame with junk data must not write
		spi_transfer(1'b0, CMD_READ, 16'(REG_START), 32'h0000_0123, rx);
		expect_value("start readback", rx, 32'(LOOP_START));
		spi_transfer(1'b0, CMD_READ, 16'(REG_START), 32'd0, rx);
		expect_value("start after read frame", rx, 32'(LOOP_START));
		// same-frame read sees the old value
		spi_transfer(1'b0, CMD_WRITE, 16'(REG_END), 32'(LOOP_END), rx);
		expect_value("end during write", rx, 32'd4);
		spi_transfer(1'b0, CMD_READ, 16'(REG_END), 32'd0, rx);
		expect_value("end readback", rx, 32'(LOOP_END));
	endtask

	task automatic memory_readback();
		logic [31:0] rx;
		logic [31:0] word;
		int w;
		int b;
		for (w = 0; w < NUM_WORDS; w++) begin
			rng_state = next_random(rng_state);
			word = rng_state;
			// big-endian so byte 4w is the top byte
			for (b = 0; b < 4; b++)
				model_bytes[4*w + b] = word[31 - 8*b -: 8];
			spi_transfer(1'b1, CMD_WRITE, 16'(4*w), word, rx);
		end
		for (w = 0; w < NUM_WORDS; w++) begin
			// low address bits are a byte offset and get dropped
			spi_transfer(1'b1, CMD_READ, 16'(4*w + w % 4), 32'd0, rx);
			expect_value($sformatf("pattern word %0d", w), rx,
				{model_bytes[4*w], model_bytes[4*w+1], model_bytes[4*w+2], model_bytes[4*w+3]});
		end
	endtask

	task automatic playback_run();
		logic [31:0] rx;
		spi_transfer(1'b0, CMD_WRITE, 16'(REG_CONTROL), 32'd1, rx);
		compare_loops(LOOP_START, LOOP_END, 2);
	endtask

	task automatic bounds_change_and_stop();
		logic [31:0] rx;
		// start goes first so end stays above start throughout
		spi_transfer(1'b0, CMD_WRITE, 16'(REG_START), 32'(NEW_START), rx);
		spi_transfer(1'b0, CMD_WRITE, 16'(REG_END), 32'(NEW_END), rx);
		compare_loops(NEW_START, NEW_END, 2);
		spi_transfer(1'b0, CMD_WRITE, 16'(REG_CONTROL), 32'd0, rx);
		repeat (8) begin
			expect_value("sample after stop", 32'(sample), 32'd0);
			@(negedge clock_ro);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence and watchdog
	// ----------------------------------------------------------------------
	initial begin
		reset4_word_clock = 1'b1;
		spi_sclk          = 1'b0;
		spi_mosi          = 1'b0;
		spi_ce0           = 1'b1;
		spi_ce1           = 1'b1;
		error_count       = 0;
		rng_state         = 32'h52df_a0dd;
		reset_defaults();
		register_access();
		memory_readback();
		playback_run();
		bounds_change_and_stop();
		$display("run complete, %0d errors", error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock_ro);
		$display("timeout after %0d cycles, tests did not complete", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: design/siggen_top.sv
// pattern generator top with two SPI slaves, control registers, pattern memory and sequencer
`timescale 1ns/1ps

module siggen_top import siggen_pkg::*; #(
	parameter int PATTERN_ADDR_BITS = 12
) (
	input  logic    clock_ro,
	input  logic    reset4_word_clock,
	input  logic    spi_sclk,
	input  logic    spi_mosi,
	input  logic    spi_ce0,
	input  logic    spi_ce1,
	output logic    spi_miso,
	output sample_t sample,
	output logic    ready
);
	// ----------------------------------------------------------------------
	// select 0, control registers
	// ----------------------------------------------------------------------
	spi_frame_t frame_ce0;
	logic miso_ce0, address_valid_ce0, transaction_valid_ce0;
	logic [31:0] read_data_ce0;
	logic [PATTERN_ADDR_BITS-1:0] start_address, end_address;
	logic run;

	spi_frame_fsm spi_ce0_i (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .ssel_n(spi_ce0), .read_data(read_data_ce0),
		.miso(miso_ce0), .address_valid(address_valid_ce0),
		.transaction_valid(transaction_valid_ce0), .frame(frame_ce0)
	);

	control_registers #(.PATTERN_ADDR_BITS(PATTERN_ADDR_BITS)) control_registers_i (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.transaction_valid(transaction_valid_ce0), .address_valid(address_valid_ce0),
		.frame(frame_ce0), .read_data(read_data_ce0),
		.start_address(start_address), .end_address(end_address), .run(run)
	);

	// ----------------------------------------------------------------------
	// select 1, pattern memory and playback
	// ----------------------------------------------------------------------
	spi_frame_t frame_ce1;
	logic miso_ce1, address_valid_ce1, transaction_valid_ce1;
	logic [31:0] read_data_ce1;
	logic [PATTERN_ADDR_BITS-1:0] read_address;
	logic [7:0] sample_byte;
	logic sync;

	spi_frame_fsm spi_ce1_i (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .ssel_n(spi_ce1), .read_data(read_data_ce1),
		.miso(miso_ce1), .address_valid(address_valid_ce1),
		.transaction_valid(transaction_valid_ce1), .frame(frame_ce1)
	);

	pattern_memory #(.PATTERN_ADDR_BITS(PATTERN_ADDR_BITS)) pattern_memory_i (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.transaction_valid(transaction_valid_ce1), .address_valid(address_valid_ce1),
		.frame(frame_ce1), .read_address(read_address),
		.read_data(read_data_ce1), .sample_byte(sample_byte)
	);

	playback_sequencer #(.PATTERN_ADDR_BITS(PATTERN_ADDR_BITS)) playback_sequencer_i (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.run(run), .start_address(start_address), .end_address(end_address),
		.read_address(read_address), .sync(sync)
	);

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------
	// ce0 low selects slave 0
	assign spi_miso = spi_ce0 ? miso_ce1 : miso_ce0;

	// run delayed by the memory latency, blanks the byte while stopped
	logic playing;

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			ready   <= 1'b0;
			playing <= 1'b0;
		end else begin
			ready   <= 1'b1;
			playing <= run;
		end
	end

	assign sample.data = playing ? sample_byte : 8'd0;
	assign sample.sync = sync;

endmodule

// File: design/playback_sequencer.sv
// wrapping byte address counter with latched loop bounds and a memory-aligned frame sync
`timescale 1ns/1ps

module playback_sequencer #(
	parameter int PATTERN_ADDR_BITS = 12
) (
	input  logic                         clock_ro,
	input  logic                         reset4_word_clock,
	input  logic                         run,
	input  logic [PATTERN_ADDR_BITS-1:0] start_address,
	input  logic [PATTERN_ADDR_BITS-1:0] end_address,
	output logic [PATTERN_ADDR_BITS-1:0] read_address,
	output logic                         sync
);
	// bounds held for the whole loop
	logic [PATTERN_ADDR_BITS-1:0] loop_start;
	logic [PATTERN_ADDR_BITS-1:0] loop_last;
	// read_address currently points at the first byte of a loop
	logic at_start;

	// ----------------------------------------------------------------------
	// address loop
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock || !run) begin
			// idle keeps tracking the registers
			read_address <= start_address;
			loop_start   <= start_address;
			loop_last    <= end_address - 1'b1;
			at_start     <= 1'b1;
			sync         <= 1'b0;
		end else begin
			// one cycle late to line up with the memory output
			sync <= at_start;
			if (read_address == loop_last) begin
				// wrap and pick up new bounds
				read_address <= start_address;
				loop_start   <= start_address;
				loop_last    <= end_address - 1'b1;
				at_start     <= 1'b1;
			end else begin
				read_address <= read_address + 1'b1;
				at_start     <= 1'b0;
			end
		end
	end

	// addresses stay inside the loop that was latched
	a_address_bounds: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		run |-> (read_address >= loop_start && read_address <= loop_last))
		else $error("read address %h outside %h..%h", read_address, loop_start, loop_last);

endmodule

// File: design/pattern_memory.sv
// dual-port pattern store with 32-bit SPI write and readback and an 8-bit playback port
`timescale 1ns/1ps

module pattern_memory import siggen_pkg::*; #(
	parameter int PATTERN_ADDR_BITS = 12
) (
	input  logic                         clock_ro,
	input  logic                         reset4_word_clock,
	input  logic                         transaction_valid,
	input  logic                         address_valid,
	input  spi_frame_t                   frame,
	input  logic [PATTERN_ADDR_BITS-1:0] read_address,
	output logic [31:0]                  read_data,
	output logic [7:0]                   sample_byte
);
	// four bytes per word
	localparam int WORD_ADDR_BITS = PATTERN_ADDR_BITS - 2;
	localparam int WORDS          = 1 << WORD_ADDR_BITS;

	logic [31:0] mem [WORDS];

	// ----------------------------------------------------------------------
	// spi side, word addressed
	// ----------------------------------------------------------------------
	logic [WORD_ADDR_BITS-1:0] spi_word;
	logic write_en;

	// byte offset bits of the frame address are dropped
	assign spi_word = frame.address[PATTERN_ADDR_BITS-1:2];
	assign write_en = transaction_valid && (frame.command == CMD_WRITE);

	always_ff @(posedge clock_ro) begin
		if (write_en)
			mem[spi_word] <= frame.data;
		// readback taken before any write of the same frame
		if (address_valid)
			read_data <= mem[spi_word];
	end

	// ----------------------------------------------------------------------
	// playback side, byte addressed
	// ----------------------------------------------------------------------
	logic [31:0] play_word;
	logic [1:0] lane;

	assign play_word = mem[read_address[PATTERN_ADDR_BITS-1:2]];
	assign lane      = read_address[1:0];

	// big-endian inside the word
	// byte 0 is bits 31..24, so the lane is inverted
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock)
			sample_byte <= '0;
		else
			sample_byte <= play_word[{~lane, 3'b000} +: 8];
	end

	// host writes above the array would alias onto low words
	a_write_in_range: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		write_en |-> (frame.address[15:PATTERN_ADDR_BITS] == '0))
		else $error("pattern write outside memory at %h", frame.address);

endmodule

// File: design/control_registers.sv
// control register bank holding start address, end address and run, with SPI readback
`timescale 1ns/1ps

module control_registers import siggen_pkg::*; #(
	parameter int PATTERN_ADDR_BITS = 12
) (
	input  logic                         clock_ro,
	input  logic                         reset4_word_clock,
	input  logic                         transaction_valid,
	input  logic                         address_valid,
	input  spi_frame_t                   frame,
	output logic [31:0]                  read_data,
	output logic [PATTERN_ADDR_BITS-1:0] start_address,
	output logic [PATTERN_ADDR_BITS-1:0] end_address,
	output logic                         run
);
	localparam int PAD_BITS = 32 - PATTERN_ADDR_BITS;

	logic [3:0] reg_index;
	logic write_en;

	assign reg_index = frame.address[3:0];
	assign write_en  = transaction_valid && (frame.command == CMD_WRITE);

	// ----------------------------------------------------------------------
	// register writes
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			start_address <= '0;
			end_address   <= PATTERN_ADDR_BITS'(4);
			run           <= 1'b0;
		end else if (write_en) begin
			case (reg_index)
				REG_START:   start_address <= frame.data[PATTERN_ADDR_BITS-1:0];
				REG_END:     end_address   <= frame.data[PATTERN_ADDR_BITS-1:0];
				REG_CONTROL: run           <= frame.data[0];
				default:     ;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// readback, sampled at the header so a write in the same frame is not seen
	// ----------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (address_valid) begin
			case (reg_index)
				REG_START:   read_data <= {{PAD_BITS{1'b0}}, start_address};
				REG_END:     read_data <= {{PAD_BITS{1'b0}}, end_address};
				REG_CONTROL: read_data <= {31'd0, run};
				// unmapped indices read as zero
				default:     read_data <= '0;
			endcase
		end
	end

	// an empty or inverted loop would run the sequencer off its bounds
	a_loop_bounds: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		run |-> (end_address > start_address))
		else $error("end address not above start address while running");

endmodule

// File: design/spi_frame_fsm.sv
// SPI mode 0 slave that deserializes 56-bit frames and shifts read data back on MISO
`timescale 1ns/1ps

module spi_frame_fsm import siggen_pkg::*; (
	input  logic       clock_ro,
	input  logic       reset4_word_clock,
	input  logic       sclk,
	input  logic       mosi,
	input  logic       ssel_n,
	input  logic [31:0] read_data,
	output logic       miso,
	output logic       address_valid,
	output logic       transaction_valid,
	output spi_frame_t frame
);
	// command + address, read data must be looked up after this many bits
	localparam int HEADER_BITS = 24;

	typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_DONE} state_t;

	// ----------------------------------------------------------------------
	// pin synchronizers and edge detect
	// ----------------------------------------------------------------------
	// [0] and [1] are the two sync stages, [2] is the previous value
	logic [2:0] ssel_pipe;
	logic [2:0] sck_pipe;
	logic [1:0] mosi_pipe;
	logic ssel_active, ssel_rise, sck_rise, sck_fall, mosi_bit;

	assign ssel_active = ~ssel_pipe[1];
	assign ssel_rise   = ssel_pipe[1] & ~ssel_pipe[2];
	assign sck_rise    = sck_pipe[1] & ~sck_pipe[2];
	assign sck_fall    = ~sck_pipe[1] & sck_pipe[2];
	assign mosi_bit    = mosi_pipe[1];

	// ----------------------------------------------------------------------
	// frame state machine
	// ----------------------------------------------------------------------
	state_t state;
	logic [5:0] bit_count;
	logic [FRAME_BITS-1:0] shift_in;
	logic [31:0] miso_shift;
	logic take_bit, frame_done;

	// a bit is taken on rising sck unless the select is closing
	assign take_bit   = (state == ST_SHIFT) && !ssel_rise && sck_rise;
	assign frame_done = (state == ST_SHIFT) && ssel_rise && (bit_count == 6'(FRAME_BITS));

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			ssel_pipe         <= 3'b111;
			sck_pipe          <= 3'b000;
			mosi_pipe         <= 2'b00;
			state             <= ST_IDLE;
			bit_count         <= '0;
			miso_shift        <= '0;
			address_valid     <= 1'b0;
			transaction_valid <= 1'b0;
		end else begin
			ssel_pipe         <= {ssel_pipe[1:0], ssel_n};
			sck_pipe          <= {sck_pipe[1:0], sclk};
			mosi_pipe         <= {mosi_pipe[0], mosi};
			address_valid     <= 1'b0;
			transaction_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (ssel_active) begin
						state      <= ST_SHIFT;
						bit_count  <= '0;
						miso_shift <= '0;
					end
				end
				ST_SHIFT: begin
					if (ssel_rise) begin
						// strobe only for a complete frame
						transaction_valid <= frame_done;
						state             <= ST_DONE;
					end else begin
						if (sck_rise) begin
							// saturate, an overlong frame never validates
							if (bit_count != '1)
								bit_count <= bit_count + 1'b1;
							if (bit_count == 6'(HEADER_BITS - 1))
								address_valid <= 1'b1;
						end
						// miso moves on falling sck
						if (sck_fall) begin
							if (bit_count == 6'(HEADER_BITS))
								miso_shift <= read_data;
							else
								miso_shift <= {miso_shift[30:0], 1'b0};
						end
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// shift register and frame output, payload only
	always_ff @(posedge clock_ro) begin
		if (take_bit) begin
			shift_in <= {shift_in[FRAME_BITS-2:0], mosi_bit};
			// header visible together with address_valid
			if (bit_count == 6'(HEADER_BITS - 1))
				{frame.command, frame.address} <= {shift_in[HEADER_BITS-2:0], mosi_bit};
		end
		if (frame_done)
			frame <= shift_in;
	end

	assign miso = miso_shift[31];

	// master must not clock more than one frame per select
	a_frame_length: assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		(state == ST_SHIFT && take_bit) |-> (bit_count < 6'(FRAME_BITS)))
		else $error("spi frame longer than %0d bits", FRAME_BITS);

endmodule

// File: design/siggen_pkg.sv
// shared frame and sample types, command code and register indices for the pattern generator
package siggen_pkg;

	// ----------------------------------------------------------------------
	// spi frame layout
	// ----------------------------------------------------------------------

	// bits per transaction, command + address + data
	localparam int FRAME_BITS = 56;

	// one spi transaction, msb first on the wire
	// so a 56-bit shift register maps straight onto it
	typedef struct packed {
		logic [7:0]  command;
		logic [15:0] address;
		logic [31:0] data;
	} spi_frame_t;

	// only this command writes, anything else is a read
	localparam logic [7:0] CMD_WRITE = 8'h57;

	// ----------------------------------------------------------------------
	// control register map (select 0)
	// ----------------------------------------------------------------------

	localparam logic [3:0] REG_START   = 4'd0;
	localparam logic [3:0] REG_END     = 4'd1;
	localparam logic [3:0] REG_CONTROL = 4'd2;

	// ----------------------------------------------------------------------
	// playback output
	// ----------------------------------------------------------------------

	// one byte per clock, sync marks first byte of a loop
	typedef struct packed {
		logic [7:0] data;
		logic       sync;
	} sample_t;

endpackage
